// File: sat_cfg_pkg.sv
// SAT bin sizing
// variable and level counts of one bin, plus the index widths derived from them

package sat_cfg_pkg;

    // variables held by one bin
    localparam int num_vars = 8;

    // decision levels, level n lives in level word n-1
    localparam int num_lvls = 8;

    // level number, wide enough for 0 .. num_lvls
    localparam int width_lvl = 4;

    // variable index inside the bin
    localparam int width_vid = 3;

    // bin number carried in the level words
    localparam int width_bin_id = 6;

endpackage

// File: sat_state_pkg.sv
// SAT state encodings
// layout of the variable and level state words, and the analysis FSM states

package sat_state_pkg;

    // variable value codes
    localparam logic [1:0] val_free  = 2'b00;
    localparam logic [1:0] val_false = 2'b01;
    localparam logic [1:0] val_true  = 2'b10;

    // variable word: value, level, conflict mark
    localparam int width_var_state = 7;
    localparam int var_val_hi  = 6;
    localparam int var_val_lo  = 5;
    localparam int var_lvl_hi  = 4;
    localparam int var_lvl_lo  = 1;
    localparam int var_cfl_bit = 0;

    // level word: open flag, flipped flag, bin number
    localparam int width_lvl_state = 8;
    localparam int lvl_open_bit = 7;
    localparam int lvl_flip_bit = 6;
    localparam int lvl_bin_hi   = 5;
    localparam int lvl_bin_lo   = 0;

    typedef enum logic [1:0] {an_idle, an_find, an_add, an_done} analyze_state_t;

endpackage

// File: var_state_bank.sv
`timescale 1ns/1ps
// variable state bank
// one state word per variable, with decision assign, backtrack clear and conflict summary

module var_state_bank (
    input  logic                                                          clk,
    input  logic                                                          rst,
    input  logic [sat_cfg_pkg::num_vars-1:0]                              wr_states_i,
    input  logic [sat_cfg_pkg::num_vars*sat_state_pkg::width_var_state-1:0] vars_states_i,
    input  logic                                                          assign_valid_i,
    input  logic [sat_cfg_pkg::width_vid-1:0]                             assign_vid_i,
    input  logic [sat_cfg_pkg::width_lvl-1:0]                             cur_lvl_i,
    input  logic                                                          apply_bkt_i,
    input  logic [sat_cfg_pkg::width_lvl-1:0]                             bkt_lvl_i,
    output logic [sat_cfg_pkg::num_vars*sat_state_pkg::width_var_state-1:0] vars_states_o,
    output logic [sat_cfg_pkg::num_vars-1:0]                              assigned_o,
    output logic [sat_cfg_pkg::num_vars-1:0]                              conflict_o,
    output logic [sat_cfg_pkg::width_lvl-1:0]                             max_lvl_o,
    output logic [2*sat_cfg_pkg::num_vars-1:0]                            learnt_lit_o
);

    import sat_cfg_pkg::*;
    import sat_state_pkg::*;

    logic [width_var_state-1:0] state_q [num_vars];

    // load first, then decision, then backtrack
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_vars; i++) begin
                state_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_vars; i++) begin
                if (wr_states_i[i]) begin
                    state_q[i] <= vars_states_i[i*width_var_state +: width_var_state];
                end else if (assign_valid_i && assign_vid_i == width_vid'(i)) begin
                    state_q[i] <= {val_false, cur_lvl_i, 1'b0};
                end else if (apply_bkt_i &&
                             state_q[i][var_lvl_hi:var_lvl_lo] > bkt_lvl_i) begin
                    // back to free, mark dropped
                    state_q[i] <= '0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_vars; i++) begin
            vars_states_o[i*width_var_state +: width_var_state] = state_q[i];
        end
    end

    always_comb begin
        for (int i = 0; i < num_vars; i++) begin
            assigned_o[i] = state_q[i][var_val_hi:var_val_lo] != val_free;
            conflict_o[i] = state_q[i][var_cfl_bit];
        end
    end

    // highest level among marked variables
    always_comb begin
        max_lvl_o = '0;
        for (int i = 0; i < num_vars; i++) begin
            if (state_q[i][var_cfl_bit] &&
                state_q[i][var_lvl_hi:var_lvl_lo] > max_lvl_o) begin
                max_lvl_o = state_q[i][var_lvl_hi:var_lvl_lo];
            end
        end
    end

    // literal is the negation of the current value, bit 1 valid, bit 0 sign
    always_comb begin
        for (int i = 0; i < num_vars; i++) begin
            learnt_lit_o[2*i+1] = state_q[i][var_cfl_bit];
            learnt_lit_o[2*i]   = state_q[i][var_cfl_bit] &&
                                  state_q[i][var_val_hi:var_val_lo] == val_true;
        end
    end

endmodule

// File: lvl_state_bank.sv
`timescale 1ns/1ps
// level state bank
// level words opened by decisions and closed by backtrack, plus the backtrack level search

module lvl_state_bank (
    input  logic                                                          clk,
    input  logic                                                          rst,
    input  logic [sat_cfg_pkg::num_lvls-1:0]                              wr_states_i,
    input  logic [sat_cfg_pkg::num_lvls*sat_state_pkg::width_lvl_state-1:0] lvl_states_i,
    input  logic                                                          open_valid_i,
    input  logic [sat_cfg_pkg::width_lvl-1:0]                             open_lvl_i,
    input  logic [sat_cfg_pkg::width_bin_id-1:0]                          cur_bin_num_i,
    input  logic [sat_cfg_pkg::width_lvl-1:0]                             max_lvl_i,
    input  logic                                                          apply_bkt_i,
    input  logic [sat_cfg_pkg::width_lvl-1:0]                             bkt_lvl_i,
    output logic [sat_cfg_pkg::num_lvls*sat_state_pkg::width_lvl_state-1:0] lvl_states_o,
    output logic [sat_cfg_pkg::width_lvl-1:0]                             bkt_lvl_o,
    output logic [sat_cfg_pkg::width_bin_id-1:0]                          bkt_bin_o
);

    import sat_cfg_pkg::*;
    import sat_state_pkg::*;

    // word i holds level i+1
    logic [width_lvl_state-1:0] state_q [num_lvls];
    logic                       found;

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_lvls; i++) begin
                state_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_lvls; i++) begin
                if (wr_states_i[i]) begin
                    state_q[i] <= lvl_states_i[i*width_lvl_state +: width_lvl_state];
                end else if (open_valid_i && open_lvl_i == width_lvl'(i + 1)) begin
                    state_q[i] <= {1'b1, 1'b0, cur_bin_num_i};
                end else if (apply_bkt_i && width_lvl'(i + 1) > bkt_lvl_i) begin
                    state_q[i] <= '0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_lvls; i++) begin
            lvl_states_o[i*width_lvl_state +: width_lvl_state] = state_q[i];
        end
    end

    // walk down from max_lvl-1, first open unflipped level wins
    always_comb begin
        found     = 1'b0;
        bkt_lvl_o = '0;
        bkt_bin_o = '0;
        for (int i = num_lvls - 1; i >= 0; i--) begin
            if (!found && width_lvl'(i + 1) < max_lvl_i &&
                state_q[i][lvl_open_bit] && !state_q[i][lvl_flip_bit]) begin
                found     = 1'b1;
                bkt_lvl_o = width_lvl'(i + 1);
                bkt_bin_o = state_q[i][lvl_bin_hi:lvl_bin_lo];
            end
        end
    end

endmodule

// File: decision_unit.sv
`timescale 1ns/1ps
// decision unit
// picks the lowest free variable and keeps the current decision level

module decision_unit (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start_i,
    input  logic [sat_cfg_pkg::num_vars-1:0]  assigned_i,
    input  logic                             apply_bkt_i,
    input  logic [sat_cfg_pkg::width_lvl-1:0] bkt_lvl_i,
    output logic                             assign_valid_o,
    output logic [sat_cfg_pkg::width_vid-1:0] assign_vid_o,
    output logic [sat_cfg_pkg::width_lvl-1:0] cur_lvl_o,
    output logic                             done_o,
    output logic                             all_assigned_o
);

    import sat_cfg_pkg::*;
    import sat_state_pkg::*;

    logic                 start_q;
    logic                 any_free;
    logic [width_vid-1:0] free_vid;

    // lowest index free variable
    always_comb begin
        any_free = 1'b0;
        free_vid = '0;
        for (int i = num_vars - 1; i >= 0; i--) begin
            if (!assigned_i[i]) begin
                any_free = 1'b1;
                free_vid = width_vid'(i);
            end
        end
    end

    assign assign_valid_o = start_q && any_free;
    assign assign_vid_o   = free_vid;

    always_ff @(posedge clk) begin
        if (!rst) begin
            start_q        <= 1'b0;
            done_o         <= 1'b0;
            all_assigned_o <= 1'b0;
        end else begin
            start_q        <= start_i;
            done_o         <= start_q;
            all_assigned_o <= start_q && !any_free;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cur_lvl_o <= '0;
        end else if (apply_bkt_i) begin
            cur_lvl_o <= bkt_lvl_i;
        end else if (assign_valid_o) begin
            cur_lvl_o <= cur_lvl_o + 1'b1;
        end
    end

endmodule

// File: state_list.sv
`timescale 1ns/1ps
// state list of one SAT bin
// variable and level states, imply and analysis control, backtrack level select

module state_list (
    input  logic                                                          clk,
    input  logic                                                          rst,
    input  logic                                                          start_decision_i,
    input  logic [sat_cfg_pkg::width_bin_id-1:0]                          cur_bin_num_i,
    input  logic                                                          apply_imply_i,
    input  logic                                                          apply_analyze_i,
    input  logic                                                          apply_bkt_cur_bin_i,
    input  logic                                                          base_lvl_en_i,
    input  logic [sat_cfg_pkg::width_lvl-1:0]                             base_lvl_i,
    input  logic [sat_cfg_pkg::num_vars-1:0]                              wr_var_states_i,
    input  logic [sat_cfg_pkg::num_vars*sat_state_pkg::width_var_state-1:0] vars_states_i,
    input  logic [sat_cfg_pkg::num_lvls-1:0]                              wr_lvl_states_i,
    input  logic [sat_cfg_pkg::num_lvls*sat_state_pkg::width_lvl_state-1:0] lvl_states_i,
    output logic [sat_cfg_pkg::width_lvl-1:0]                             cur_lvl_o,
    output logic                                                          done_decision_o,
    output logic                                                          all_assigned_o,
    output logic                                                          done_imply_o,
    output logic                                                          find_conflict_o,
    output logic                                                          add_learntc_en_o,
    output logic                                                          done_analyze_o,
    output logic [2*sat_cfg_pkg::num_vars-1:0]                            learnt_lit_o,
    output logic [sat_cfg_pkg::width_lvl-1:0]                             bkt_lvl_o,
    output logic [sat_cfg_pkg::width_bin_id-1:0]                          bkt_bin_o,
    output logic                                                          done_bkt_cur_bin_o,
    output logic [sat_cfg_pkg::num_vars*sat_state_pkg::width_var_state-1:0] vars_states_o,
    output logic [sat_cfg_pkg::num_lvls*sat_state_pkg::width_lvl_state-1:0] lvl_states_o
);

    import sat_cfg_pkg::*;
    import sat_state_pkg::*;

    logic [num_vars-1:0]  assigned;
    logic [num_vars-1:0]  assigned_q;
    logic [num_vars-1:0]  conflict;
    logic [num_vars-1:0]  conflict_q;
    logic [width_lvl-1:0] max_lvl;
    logic [width_lvl-1:0] search_lvl;
    logic [width_lvl-1:0] base_lvl_q;
    logic [width_lvl-1:0] dec_lvl;
    logic                 assign_valid;
    logic [width_vid-1:0] assign_vid;
    analyze_state_t       an_state;
    analyze_state_t       an_next;

    // a decision lands one level above the current one
    assign dec_lvl = cur_lvl_o + 1'b1;

    var_state_bank u_var_state_bank (
        .clk            (clk),
        .rst            (rst),
        .wr_states_i    (wr_var_states_i),
        .vars_states_i  (vars_states_i),
        .assign_valid_i (assign_valid),
        .assign_vid_i   (assign_vid),
        .cur_lvl_i      (dec_lvl),
        .apply_bkt_i    (apply_bkt_cur_bin_i),
        .bkt_lvl_i      (bkt_lvl_o),
        .vars_states_o  (vars_states_o),
        .assigned_o     (assigned),
        .conflict_o     (conflict),
        .max_lvl_o      (max_lvl),
        .learnt_lit_o   (learnt_lit_o)
    );

    lvl_state_bank u_lvl_state_bank (
        .clk           (clk),
        .rst           (rst),
        .wr_states_i   (wr_lvl_states_i),
        .lvl_states_i  (lvl_states_i),
        .open_valid_i  (assign_valid),
        .open_lvl_i    (dec_lvl),
        .cur_bin_num_i (cur_bin_num_i),
        .max_lvl_i     (max_lvl),
        .apply_bkt_i   (apply_bkt_cur_bin_i),
        .bkt_lvl_i     (bkt_lvl_o),
        .lvl_states_o  (lvl_states_o),
        .bkt_lvl_o     (search_lvl),
        .bkt_bin_o     (bkt_bin_o)
    );

    decision_unit u_decision_unit (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_decision_i),
        .assigned_i     (assigned),
        .apply_bkt_i    (apply_bkt_cur_bin_i),
        .bkt_lvl_i      (bkt_lvl_o),
        .assign_valid_o (assign_valid),
        .assign_vid_o   (assign_vid),
        .cur_lvl_o      (cur_lvl_o),
        .done_o         (done_decision_o),
        .all_assigned_o (all_assigned_o)
    );

    assign find_conflict_o = |conflict;

    // conflicts below the base level go back across bins
    assign bkt_lvl_o = (max_lvl < base_lvl_q) ? max_lvl : search_lvl;

    always_ff @(posedge clk) begin
        if (!rst) begin
            assigned_q   <= '0;
            conflict_q   <= '0;
            done_imply_o <= 1'b0;
        end else begin
            assigned_q   <= assigned;
            conflict_q   <= conflict;
            // settled once the mask stops moving
            done_imply_o <= apply_imply_i && (assigned == assigned_q || find_conflict_o);
        end
    end

    always_comb begin
        case (an_state)
            an_idle: an_next = apply_analyze_i ? an_find : an_idle;
            an_find: an_next = (conflict == conflict_q) ? an_add : an_find;
            an_add:  an_next = an_done;
            an_done: an_next = apply_analyze_i ? an_done : an_idle;
            default: an_next = an_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            an_state         <= an_idle;
            add_learntc_en_o <= 1'b0;
            done_analyze_o   <= 1'b0;
        end else begin
            an_state         <= an_next;
            add_learntc_en_o <= an_state == an_add;
            done_analyze_o   <= an_state == an_done;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            base_lvl_q         <= '0;
            done_bkt_cur_bin_o <= 1'b0;
        end else begin
            if (base_lvl_en_i) begin
                base_lvl_q <= base_lvl_i;
            end
            done_bkt_cur_bin_o <= apply_bkt_cur_bin_i;
        end
    end

endmodule

// File: tb_state_list.sv
`timescale 1ns/1ps
// testbench for the SAT bin state list
// random decisions, loads, imply, analyze and backtrack checked against a behavioral model

module tb_state_list;

    import sat_cfg_pkg::*;
    import sat_state_pkg::*;

    localparam int num_ops     = 300;
    localparam int cycle_limit = 40 * num_ops + 200;
    localparam int wv          = width_var_state;
    localparam int wl          = width_lvl_state;

    logic                            clk;
    logic                            rst;
    logic                            start_decision_i;
    logic [width_bin_id-1:0]         cur_bin_num_i;
    logic                            apply_imply_i;
    logic                            apply_analyze_i;
    logic                            apply_bkt_cur_bin_i;
    logic                            base_lvl_en_i;
    logic [width_lvl-1:0]            base_lvl_i;
    logic [num_vars-1:0]             wr_var_states_i;
    logic [num_vars*wv-1:0]          vars_states_i;
    logic [num_lvls-1:0]             wr_lvl_states_i;
    logic [num_lvls*wl-1:0]          lvl_states_i;
    logic [width_lvl-1:0]            cur_lvl_o;
    logic                            done_decision_o;
    logic                            all_assigned_o;
    logic                            done_imply_o;
    logic                            find_conflict_o;
    logic                            add_learntc_en_o;
    logic                            done_analyze_o;
    logic [2*num_vars-1:0]           learnt_lit_o;
    logic [width_lvl-1:0]            bkt_lvl_o;
    logic [width_bin_id-1:0]         bkt_bin_o;
    logic                            done_bkt_cur_bin_o;
    logic [num_vars*wv-1:0]          vars_states_o;
    logic [num_lvls*wl-1:0]          lvl_states_o;

    // reference copy of the bin state
    logic [wv-1:0]                   m_var [num_vars];
    logic [wl-1:0]                   m_lvl [num_lvls];
    logic [width_lvl-1:0]            m_cur;
    logic [width_lvl-1:0]            m_base;
    logic [num_vars-1:0]             pend_mask;
    logic [num_vars*wv-1:0]          pend_words;
    int                              errors;
    int                              cycles;
    int unsigned                     seed_val;

    state_list u_state_list (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    function automatic logic [num_vars-1:0] model_assigned();
        logic [num_vars-1:0] m;
        for (int i = 0; i < num_vars; i++) begin
            m[i] = m_var[i][var_val_hi:var_val_lo] != val_free;
        end
        return m;
    endfunction

    function automatic logic [num_vars-1:0] model_marks();
        logic [num_vars-1:0] m;
        for (int i = 0; i < num_vars; i++) begin
            m[i] = m_var[i][var_cfl_bit];
        end
        return m;
    endfunction

    // max conflict level, then the highest open unflipped level under it
    task automatic model_bkt(output logic [width_lvl-1:0]    lvl,
                             output logic [width_bin_id-1:0] bin);
        logic [width_lvl-1:0] mx;
        mx  = '0;
        lvl = '0;
        bin = '0;
        for (int i = 0; i < num_vars; i++) begin
            if (m_var[i][var_cfl_bit] && m_var[i][var_lvl_hi:var_lvl_lo] > mx) begin
                mx = m_var[i][var_lvl_hi:var_lvl_lo];
            end
        end
        for (int i = 0; i < num_lvls; i++) begin
            if (width_lvl'(i + 1) < mx && m_lvl[i][lvl_open_bit] && !m_lvl[i][lvl_flip_bit]) begin
                lvl = width_lvl'(i + 1);
                bin = m_lvl[i][lvl_bin_hi:lvl_bin_lo];
            end
        end
        if (mx < m_base) begin
            lvl = mx;
        end
    endtask

    task automatic compare_state();
        logic [width_lvl-1:0]    bl;
        logic [width_bin_id-1:0] bb;
        model_bkt(bl, bb);
        for (int i = 0; i < num_vars; i++) begin
            if (vars_states_o[i*wv +: wv] !== m_var[i]) begin
                report_error($sformatf("var %0d word %h, expected %h",
                                       i, vars_states_o[i*wv +: wv], m_var[i]));
            end
        end
        for (int i = 0; i < num_lvls; i++) begin
            if (lvl_states_o[i*wl +: wl] !== m_lvl[i]) begin
                report_error($sformatf("level %0d word %h, expected %h",
                                       i + 1, lvl_states_o[i*wl +: wl], m_lvl[i]));
            end
        end
        if (cur_lvl_o !== m_cur) begin
            report_error($sformatf("cur_lvl %0d, expected %0d", cur_lvl_o, m_cur));
        end
        if (find_conflict_o !== |model_marks()) begin
            report_error("find_conflict does not match the conflict marks");
        end
        if (bkt_lvl_o !== bl || bkt_bin_o !== bb) begin
            report_error($sformatf("backtrack %0d/%0d, expected %0d/%0d",
                                   bkt_lvl_o, bkt_bin_o, bl, bb));
        end
    endtask

    // free words carry no level and no mark
    function automatic logic [wv-1:0] rand_var_word();
        int unsigned r;
        r = $urandom % 3;
        if (r == 0) begin
            return '0;
        end
        return {(r == 1) ? val_false : val_true,
                width_lvl'($urandom_range(num_lvls, 1)), ($urandom % 4) == 0};
    endfunction

    function automatic logic [wl-1:0] rand_lvl_word();
        return {($urandom % 4) != 0, ($urandom % 4) == 0, width_bin_id'($urandom)};
    endfunction

    task automatic drive_var_load();
        for (int i = 0; i < num_vars; i++) begin
            pend_words[i*wv +: wv] = rand_var_word();
        end
        pend_mask = num_vars'($urandom);
        wr_var_states_i <= pend_mask;
        vars_states_i   <= pend_words;
    endtask

    task automatic commit_var_load();
        for (int i = 0; i < num_vars; i++) begin
            if (pend_mask[i]) begin
                m_var[i] = pend_words[i*wv +: wv];
            end
        end
    endtask

    task automatic decide();
        logic [width_bin_id-1:0] bin;
        logic [num_vars-1:0]     mask;
        int                      pick;
        int                      n;
        bin  = width_bin_id'($urandom);
        @(posedge clk);
        start_decision_i <= 1'b1;
        cur_bin_num_i    <= bin;
        @(posedge clk);
        start_decision_i <= 1'b0;
        mask = model_assigned();
        pick = -1;
        for (int i = num_vars - 1; i >= 0; i--) begin
            if (!mask[i]) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            m_var[pick] = {val_false, width_lvl'(m_cur + 1), 1'b0};
            m_lvl[m_cur] = {1'b1, 1'b0, bin};
            m_cur = width_lvl'(m_cur + 1);
        end
        n = 1;
        @(negedge clk);
        while (!done_decision_o && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (n != 2) begin
            report_error($sformatf("decision done after %0d cycles, expected 2", n));
        end
        if (all_assigned_o !== (pick < 0)) begin
            report_error("all_assigned does not match the free variables");
        end
        compare_state();
        @(negedge clk);
        if (done_decision_o) begin
            report_error("decision done held longer than one cycle");
        end
    endtask

    task automatic load_states();
        logic [num_lvls-1:0]    lmask;
        logic [num_lvls*wl-1:0] lwords;
        lmask = num_lvls'($urandom);
        for (int i = 0; i < num_lvls; i++) begin
            lwords[i*wl +: wl] = rand_lvl_word();
        end
        @(posedge clk);
        drive_var_load();
        wr_lvl_states_i <= lmask;
        lvl_states_i    <= lwords;
        @(posedge clk);
        wr_var_states_i <= '0;
        wr_lvl_states_i <= '0;
        commit_var_load();
        for (int i = 0; i < num_lvls; i++) begin
            if (lmask[i]) begin
                m_lvl[i] = lwords[i*wl +: wl];
            end
        end
        @(negedge clk);
        compare_state();
    endtask

    // done follows a cycle with the request high and a settled mask or a conflict
    task automatic imply_settle();
        logic [num_vars-1:0] m1;
        logic [num_vars-1:0] m2;
        logic                cf1;
        logic                ap1;
        logic                pending;
        logic                seen;
        logic                expect_done;
        int                  nloads;
        m1      = model_assigned();
        m2      = m1;
        cf1     = |model_marks();
        ap1     = 1'b0;
        pending = 1'b0;
        seen    = 1'b0;
        nloads  = 1 + int'($urandom % 3);
        for (int i = 0; i < nloads + 5; i++) begin
            @(posedge clk);
            if (pending) begin
                commit_var_load();
                pending = 1'b0;
            end
            if (i < nloads) begin
                drive_var_load();
                pending = 1'b1;
            end else begin
                wr_var_states_i <= '0;
            end
            apply_imply_i <= (i < nloads + 3);
            @(negedge clk);
            expect_done = ap1 && (m1 == m2 || cf1);
            if (done_imply_o !== expect_done) begin
                report_error($sformatf("done_imply %b, expected %b", done_imply_o, expect_done));
            end
            if (i >= nloads && i <= nloads + 2 && done_imply_o) begin
                seen = 1'b1;
            end
            m2  = m1;
            m1  = model_assigned();
            cf1 = |model_marks();
            ap1 = apply_imply_i;
            compare_state();
        end
        if (!seen) begin
            $display("imply did not report settled within 3 cycles after the loads");
            errors++;
        end
    endtask

    task automatic analyze_conflict();
        logic [2*num_vars-1:0] exp_lit;
        logic [1:0]            inv_val;
        int                    hold;
        hold = 4 + int'($urandom % 3);
        // a marked variable learns the literal of its opposite value
        for (int i = 0; i < num_vars; i++) begin
            inv_val = (m_var[i][var_val_hi:var_val_lo] == val_true) ? val_false : val_true;
            exp_lit[2*i+1] = m_var[i][var_cfl_bit];
            exp_lit[2*i]   = m_var[i][var_cfl_bit] && inv_val == val_false;
        end
        @(posedge clk);
        apply_analyze_i <= 1'b1;
        for (int n = 0; n <= hold; n++) begin
            @(negedge clk);
            if (add_learntc_en_o !== (n == 3)) begin
                report_error($sformatf("add_learntc_en %b at cycle %0d", add_learntc_en_o, n));
            end
            if (done_analyze_o !== (n >= 4)) begin
                report_error($sformatf("done_analyze %b at cycle %0d", done_analyze_o, n));
            end
            if (n == 3 && learnt_lit_o !== exp_lit) begin
                report_error($sformatf("learnt literals %h, expected %h", learnt_lit_o, exp_lit));
            end
        end
        @(posedge clk);
        apply_analyze_i <= 1'b0;
        repeat (3) @(negedge clk);
        if (done_analyze_o || add_learntc_en_o) begin
            report_error("analysis outputs still high after the request dropped");
        end
        compare_state();
    endtask

    task automatic load_base();
        logic [width_lvl-1:0] b;
        b = width_lvl'($urandom_range(num_lvls, 0));
        @(posedge clk);
        base_lvl_en_i <= 1'b1;
        base_lvl_i    <= b;
        @(posedge clk);
        base_lvl_en_i <= 1'b0;
        m_base = b;
        @(negedge clk);
        compare_state();
    endtask

    task automatic backtrack();
        logic [width_lvl-1:0]    bl;
        logic [width_bin_id-1:0] bb;
        int                      n;
        model_bkt(bl, bb);
        @(posedge clk);
        apply_bkt_cur_bin_i <= 1'b1;
        @(posedge clk);
        apply_bkt_cur_bin_i <= 1'b0;
        for (int i = 0; i < num_vars; i++) begin
            if (m_var[i][var_lvl_hi:var_lvl_lo] > bl) begin
                m_var[i] = '0;
            end
        end
        for (int i = 0; i < num_lvls; i++) begin
            if (width_lvl'(i + 1) > bl) begin
                m_lvl[i] = '0;
            end
        end
        m_cur = bl;
        n = 1;
        @(negedge clk);
        while (!done_bkt_cur_bin_o && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (n != 1) begin
            report_error($sformatf("backtrack done after %0d cycles, expected 1", n));
        end
        compare_state();
    endtask

    initial begin
        int unsigned sel;
        seed_val            = $urandom(32510);
        errors              = 0;
        cycles              = 0;
        clk                 = 1'b0;
        rst                 = 1'b0;
        start_decision_i    = 1'b0;
        cur_bin_num_i       = '0;
        apply_imply_i       = 1'b0;
        apply_analyze_i     = 1'b0;
        apply_bkt_cur_bin_i = 1'b0;
        base_lvl_en_i       = 1'b0;
        base_lvl_i          = '0;
        wr_var_states_i     = '0;
        vars_states_i       = '0;
        wr_lvl_states_i     = '0;
        lvl_states_i        = '0;
        for (int i = 0; i < num_vars; i++) begin
            m_var[i] = '0;
        end
        for (int i = 0; i < num_lvls; i++) begin
            m_lvl[i] = '0;
        end
        m_cur  = '0;
        m_base = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        compare_state();
        for (int op = 0; op < num_ops; op++) begin
            sel = $urandom % 7;
            case (sel)
                0, 1: begin
                    // no room above the top level
                    if (m_cur < width_lvl'(num_lvls)) begin
                        decide();
                    end else begin
                        backtrack();
                    end
                end
                2: load_states();
                3: imply_settle();
                4: analyze_conflict();
                5: load_base();
                default: backtrack();
            endcase
        end
        $display("operations: %0d  errors: %0d", num_ops, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: list.f
sat_cfg_pkg.sv
sat_state_pkg.sv
var_state_bank.sv
lvl_state_bank.sv
decision_unit.sv
state_list.sv
tb_state_list.sv

// File: run_sim.sh
#!/bin/sh
# build and run the state list testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_state_list -o sim_state_list
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_state_list)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation ended with an error status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
